//--- bench/rename_stage_tb.sv
// rename stage testbench
`timescale 1ns/1ps

module rename_stage_tb;
    import arch_pkg::*;
    import packet_pkg::*;

    typedef logic [rob_idx_len-1:0] slot_t;

    // one in-flight instruction, oldest at index 0
    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        logic     done;
    } shadow_entry;

    // directed part plus random run plus slack
    localparam int directed_cycles = 400;
    localparam int random_cycles   = 2000;
    localparam int max_cycles      = directed_cycles + random_cycles + 600;

    logic           clock;
    logic           rst_n;
    logic           squash;
    dispatch_packet dispatch;
    cdb_packet      cdb;
    lookup_packet   lookup;
    retire_packet   retire;
    logic           rob_full;

    ////////////////////
    // shadow model
    ////////////////////

    shadow_entry rob_q[$];
    // slot the next dispatch gets
    slot_t       next_slot;
    rob_tag_t    map_tag [reg_count];
    logic        map_ready [reg_count];
    // map after the cycle being driven
    rob_tag_t    next_map_tag [reg_count];
    logic        next_map_ready [reg_count];

    // expected outputs for the cycle on the pins
    lookup_packet exp_lookup;
    retire_packet exp_retire;
    logic         exp_full;

    int errors;
    int cycle_count;
    int retire_count;
    int full_cycles;

    rename_stage dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .lookup   (lookup),
        .retire   (retire),
        .rob_full (rob_full)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // hard stop
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic void log_mismatch(input string name, input int got, input int want);
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
    endfunction

    function automatic void reset_shadow();
        rob_q.delete();
        next_slot = '0;
        for (int i = 0; i < reg_count; i++) begin
            map_tag[i]   = zero_tag;
            map_ready[i] = 1'b0;
        end
    endfunction

    // expected outputs from shadow state and the inputs now driven
    function automatic void predict_outputs();
        exp_full = (rob_q.size() == rob_depth);
        if (exp_full) begin
            full_cycles++;
        end
        // head leaves once done, never during squash
        exp_retire = '0;
        if (!squash && rob_q.size() != 0 && rob_q[0].done) begin
            exp_retire.valid = 1'b1;
            exp_retire.rd    = rob_q[0].rd;
            exp_retire.tag   = rob_q[0].tag;
        end
        for (int i = 0; i < reg_count; i++) begin
            next_map_tag[i]   = squash ? zero_tag : map_tag[i];
            next_map_ready[i] = squash ? 1'b0 : map_ready[i];
        end
        if (!squash) begin
            // freed only if nobody remapped rd since
            if (exp_retire.valid && next_map_tag[exp_retire.rd] == exp_retire.tag) begin
                next_map_tag[exp_retire.rd]   = zero_tag;
                next_map_ready[exp_retire.rd] = 1'b0;
            end
            if (cdb.valid) begin
                for (int i = 0; i < reg_count; i++) begin
                    if (next_map_tag[i] == cdb.tag) begin
                        next_map_ready[i] = 1'b1;
                    end
                end
            end
            if (dispatch.enable) begin
                next_map_tag[dispatch.rd]   = {1'b0, next_slot};
                next_map_ready[dispatch.rd] = 1'b0;
            end
        end
        exp_lookup.rs1_tag   = next_map_tag[dispatch.rs1];
        exp_lookup.rs2_tag   = next_map_tag[dispatch.rs2];
        exp_lookup.rs1_ready = next_map_ready[dispatch.rs1];
        exp_lookup.rs2_ready = next_map_ready[dispatch.rs2];
    endfunction

    // apply the cycle just clocked to the shadow state
    function automatic void commit_shadow();
        shadow_entry e;
        if (squash) begin
            rob_q.delete();
            next_slot = '0;
        end else begin
            if (exp_retire.valid) begin
                void'(rob_q.pop_front());
                retire_count++;
            end
            if (cdb.valid) begin
                foreach (rob_q[i]) begin
                    if (rob_q[i].tag == cdb.tag) begin
                        rob_q[i].done = 1'b1;
                    end
                end
            end
            if (dispatch.enable) begin
                e.rd   = dispatch.rd;
                e.tag  = {1'b0, next_slot};
                e.done = 1'b0;
                rob_q.push_back(e);
                next_slot = next_slot + slot_t'(1);
            end
        end
        map_tag   = next_map_tag;
        map_ready = next_map_ready;
    endfunction

    function automatic dispatch_packet pack_dispatch(input logic en, input int rd,
                                                     input int rs1, input int rs2);
        dispatch_packet d;
        d.enable = en;
        d.rd     = reg_idx_t'(rd);
        d.rs1    = reg_idx_t'(rs1);
        d.rs2    = reg_idx_t'(rs2);
        return d;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // inputs change 1 ns after the edge
    task automatic next_edge();
        @(posedge clock);
        #1;
        commit_shadow();
    endtask

    task automatic drive(input dispatch_packet d, input cdb_packet c, input logic sq);
        dispatch = d;
        cdb      = c;
        squash   = sq;
        predict_outputs();
    endtask

    task automatic dispatch_one(input int rd, input int rs1, input int rs2);
        next_edge();
        // hold off while full
        while (rob_q.size() == rob_depth) begin
            drive(pack_dispatch(1'b0, rd, rs1, rs2), '0, 1'b0);
            next_edge();
        end
        drive(pack_dispatch(1'b1, rd, rs1, rs2), '0, 1'b0);
    endtask

    task automatic broadcast(input int slot, input int rs1, input int rs2);
        cdb_packet c;
        next_edge();
        c.valid = 1'b1;
        c.tag   = {1'b0, slot_t'(slot)};
        drive(pack_dispatch(1'b0, 0, rs1, rs2), c, 1'b0);
    endtask

    task automatic idle(input int n, input int rs1, input int rs2);
        repeat (n) begin
            next_edge();
            drive(pack_dispatch(1'b0, 0, rs1, rs2), '0, 1'b0);
        end
    endtask

    // dispatch rides along and must be dropped
    task automatic squash_now(input int rd, input int rs1, input int rs2);
        next_edge();
        drive(pack_dispatch(rob_q.size() < rob_depth, rd, rs1, rs2), '0, 1'b1);
    endtask

    task automatic random_cycle();
        dispatch_packet d;
        cdb_packet      c;
        logic           sq;
        rob_tag_t       open_tags[$];
        next_edge();
        // only entries still waiting for a result
        foreach (rob_q[i]) begin
            if (!rob_q[i].done) begin
                open_tags.push_back(rob_q[i].tag);
            end
        end
        d = pack_dispatch(1'b0, $urandom_range(0, reg_count - 1),
                          $urandom_range(0, reg_count - 1), $urandom_range(0, reg_count - 1));
        d.enable = (rob_q.size() < rob_depth) && ($urandom_range(0, 3) != 0);
        c = '0;
        if (open_tags.size() != 0 && $urandom_range(0, 1) == 1) begin
            c.valid = 1'b1;
            c.tag   = open_tags[$urandom_range(0, open_tags.size() - 1)];
        end
        sq = ($urandom_range(0, 63) == 0);
        drive(d, c, sq);
    endtask

    ////////////////////
    // checks
    ////////////////////

    rs1_tag_check: assert property (@(posedge clock) disable iff (!rst_n)
        lookup.rs1_tag == exp_lookup.rs1_tag)
        else log_mismatch("lookup.rs1_tag", int'($sampled(lookup.rs1_tag)),
                          int'($sampled(exp_lookup.rs1_tag)));
    rs2_tag_check: assert property (@(posedge clock) disable iff (!rst_n)
        lookup.rs2_tag == exp_lookup.rs2_tag)
        else log_mismatch("lookup.rs2_tag", int'($sampled(lookup.rs2_tag)),
                          int'($sampled(exp_lookup.rs2_tag)));
    rs1_ready_check: assert property (@(posedge clock) disable iff (!rst_n)
        lookup.rs1_ready == exp_lookup.rs1_ready)
        else log_mismatch("lookup.rs1_ready", int'($sampled(lookup.rs1_ready)),
                          int'($sampled(exp_lookup.rs1_ready)));
    rs2_ready_check: assert property (@(posedge clock) disable iff (!rst_n)
        lookup.rs2_ready == exp_lookup.rs2_ready)
        else log_mismatch("lookup.rs2_ready", int'($sampled(lookup.rs2_ready)),
                          int'($sampled(exp_lookup.rs2_ready)));
    retire_valid_check: assert property (@(posedge clock) disable iff (!rst_n)
        retire.valid == exp_retire.valid)
        else log_mismatch("retire.valid", int'($sampled(retire.valid)),
                          int'($sampled(exp_retire.valid)));
    // payload only counts on a strobe
    retire_rd_check: assert property (@(posedge clock) disable iff (!rst_n)
        exp_retire.valid |-> retire.rd == exp_retire.rd)
        else log_mismatch("retire.rd", int'($sampled(retire.rd)),
                          int'($sampled(exp_retire.rd)));
    retire_tag_check: assert property (@(posedge clock) disable iff (!rst_n)
        exp_retire.valid |-> retire.tag == exp_retire.tag)
        else log_mismatch("retire.tag", int'($sampled(retire.tag)),
                          int'($sampled(exp_retire.tag)));
    full_check: assert property (@(posedge clock) disable iff (!rst_n)
        rob_full == exp_full)
        else log_mismatch("rob_full", int'($sampled(rob_full)), int'($sampled(exp_full)));

    initial begin
        int order [8];
        void'($urandom(88));
        errors       = 0;
        cycle_count  = 0;
        retire_count = 0;
        full_cycles  = 0;
        rst_n    = 1'b0;
        squash   = 1'b0;
        dispatch = '0;
        cdb      = '0;
        reset_shadow();
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        drive('0, '0, 1'b0);

        // every register starts unmapped
        for (int i = 0; i < reg_count / 2; i++) begin
            next_edge();
            drive(pack_dispatch(1'b0, 0, 2 * i, 2 * i + 1), '0, 1'b0);
        end

        // fill the buffer, each one reads its own rd
        for (int i = 0; i < rob_depth; i++) begin
            dispatch_one(i + 1, i + 1, i);
        end
        idle(2, 1, 8);

        // out of order results, in order retire
        order = '{5, 2, 0, 7, 1, 3, 6, 4};
        foreach (order[i]) begin
            broadcast(order[i], order[i] + 1, 1);
        end
        idle(10, 3, 6);

        // r7 renamed twice, older retire keeps the newer tag
        dispatch_one(7, 7, 0);
        dispatch_one(7, 7, 9);
        dispatch_one(9, 7, 9);
        broadcast(0, 7, 9);
        broadcast(2, 9, 7);
        idle(2, 7, 9);
        broadcast(1, 7, 9);
        idle(4, 7, 9);

        // squash mid flight, allocation restarts at slot 0
        dispatch_one(3, 1, 2);
        dispatch_one(5, 3, 3);
        broadcast(3, 3, 5);
        squash_now(6, 3, 5);
        dispatch_one(4, 3, 4);
        dispatch_one(3, 4, 3);
        idle(2, 4, 3);

        repeat (random_cycles) begin
            random_cycle();
        end
        idle(2, 0, 0);

        if (retire_count == 0) begin
            errors++;
            $display("no instruction retired during the run");
        end
        if (full_cycles == 0) begin
            errors++;
            $display("reorder buffer never became full");
        end
        $display("errors: %0d, cycles: %0d, retired: %0d", errors, cycle_count, retire_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rename_stage.f
source/arch_pkg.sv
source/packet_pkg.sv
source/map_table.sv
source/reorder_buffer.sv
source/rename_stage.sv
bench/rename_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f rename_stage.f \
    --top-module rename_stage_tb -o rename_stage_sim

status=0
output=$(./obj_dir/rename_stage_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- source/arch_pkg.sv
// architectural sizes and tags
package arch_pkg;

    ////////////////////
    // register file
    ////////////////////

    // architectural registers visible to dispatch
    localparam int reg_count = 32;
    // bits to index one register
    localparam int reg_idx_len = $clog2(reg_count);

    ////////////////////
    // reorder buffer
    ////////////////////

    // in-flight entries
    localparam int rob_depth = 8;
    // slot index width, depth is a power of two
    localparam int rob_idx_len = 3;

    // register index
    typedef logic [reg_idx_len-1:0] reg_idx_t;

    // rename tag
    // high bit set -> value sits in the register file
    // low bits -> reorder buffer slot
    typedef logic [rob_idx_len:0] rob_tag_t;

    // no producer in flight
    localparam rob_tag_t zero_tag = {1'b1, {rob_idx_len{1'b0}}};

endpackage

//--- source/map_table.sv
// register map table
`timescale 1ns/1ps

module map_table (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        squash,
    input  packet_pkg::dispatch_packet  dispatch,
    input  packet_pkg::rob_alloc_packet rob_alloc,
    input  packet_pkg::cdb_packet       cdb,
    input  packet_pkg::retire_packet    retire,
    output packet_pkg::lookup_packet    lookup
);
    import arch_pkg::*;

    ////////////////////
    // map state
    ////////////////////

    // current producer tag per register
    rob_tag_t [reg_count-1:0] tag_q;
    // producer finished and value waits in the buffer
    logic [reg_count-1:0]     ready_q;

    // state after this cycle's updates
    rob_tag_t [reg_count-1:0] tag_d;
    logic [reg_count-1:0]     ready_d;

    // retiring tag still owns its register
    logic                     retire_hit;

    assign retire_hit = retire.valid && (tag_q[retire.rd] == retire.tag);

    ////////////////////
    // next state
    ////////////////////

    // order matters here
    // retire, then broadcast, then dispatch
    always_comb begin
        tag_d   = tag_q;
        ready_d = ready_q;

        if (squash) begin
            // everything back to the register file
            tag_d   = {reg_count{zero_tag}};
            ready_d = '0;
        end else begin
            // retire only clears an unchanged mapping
            // a newer rename keeps its tag
            if (retire_hit) begin
                tag_d[retire.rd]   = zero_tag;
                ready_d[retire.rd] = 1'b0;
            end

            // broadcast wakes every register on that tag
            if (cdb.valid) begin
                for (int i = 0; i < reg_count; i++) begin
                    if (tag_d[i] == cdb.tag) begin
                        ready_d[i] = 1'b1;
                    end
                end
            end

            // new producer for rd
            if (dispatch.enable) begin
                tag_d[dispatch.rd]   = rob_alloc.tail;
                ready_d[dispatch.rd] = 1'b0;
            end
        end
    end

    ////////////////////
    // lookup
    ////////////////////

    // sources see this cycle's rename and wakeup
    // an instruction reading its own rd gets its own tag
    assign lookup.rs1_tag   = tag_d[dispatch.rs1];
    assign lookup.rs2_tag   = tag_d[dispatch.rs2];
    assign lookup.rs1_ready = ready_d[dispatch.rs1];
    assign lookup.rs2_ready = ready_d[dispatch.rs2];

    ////////////////////
    // state registers
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tag_q   <= {reg_count{zero_tag}};
            ready_q <= '0;
        end else begin
            tag_q   <= tag_d;
            ready_q <= ready_d;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // buffer only broadcasts real slots
    cdb_not_zero_tag: assert property (
        @(posedge clock) disable iff (!rst_n)
        cdb.valid |-> !cdb.tag[rob_idx_len]
    ) else $error("map_table: broadcast of register file tag %0h", cdb.tag);

endmodule

//--- source/packet_pkg.sv
// rename stage packets
package packet_pkg;
    import arch_pkg::*;

    // one instruction from dispatch, 16 bits
    typedef struct packed {
        logic     enable;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } dispatch_packet;

    // result broadcast on the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } cdb_packet;

    // head entry leaving the reorder buffer
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        rob_tag_t tag;
    } retire_packet;

    // source operand lookup result
    // ready only means something for a buffer tag
    typedef struct packed {
        rob_tag_t rs1_tag;
        rob_tag_t rs2_tag;
        logic     rs1_ready;
        logic     rs2_ready;
    } lookup_packet;

    // allocation state from the buffer
    typedef struct packed {
        rob_tag_t tail;
        logic     full;
    } rob_alloc_packet;

endpackage

//--- source/rename_stage.sv
// register rename stage
`timescale 1ns/1ps

module rename_stage (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      squash,
    input  packet_pkg::dispatch_packet dispatch,
    input  packet_pkg::cdb_packet      cdb,
    output packet_pkg::lookup_packet   lookup,
    output packet_pkg::retire_packet   retire,
    output logic                      rob_full
);
    import arch_pkg::*;
    import packet_pkg::*;

    // tail and full from the buffer
    rob_alloc_packet rob_alloc;
    // retire fields, packed for the map
    retire_packet    retire_bus;
    logic            retire_valid;
    reg_idx_t        retire_rd;
    rob_tag_t        retire_tag;

    ////////////////////
    // reorder buffer
    ////////////////////

    // only rd matters for allocation
    reorder_buffer u_rob (
        .clock           (clock),
        .rst_n           (rst_n),
        .squash          (squash),
        .dispatch_enable (dispatch.enable),
        .dispatch_rd     (dispatch.rd),
        .cdb_valid       (cdb.valid),
        .cdb_tag         (cdb.tag),
        .rob_alloc       (rob_alloc),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_tag      (retire_tag)
    );

    assign retire_bus.valid = retire_valid;
    assign retire_bus.rd    = retire_rd;
    assign retire_bus.tag   = retire_tag;

    // same strobe to the outside and the map
    assign retire   = retire_bus;
    assign rob_full = rob_alloc.full;

    ////////////////////
    // map table
    ////////////////////

    map_table u_map (
        .clock     (clock),
        .rst_n     (rst_n),
        .squash    (squash),
        .dispatch  (dispatch),
        .rob_alloc (rob_alloc),
        .cdb       (cdb),
        .retire    (retire_bus),
        .lookup    (lookup)
    );

endmodule

//--- source/reorder_buffer.sv
// in-order reorder buffer
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        squash,
    input  logic                        dispatch_enable,
    input  arch_pkg::reg_idx_t          dispatch_rd,
    input  logic                        cdb_valid,
    input  arch_pkg::rob_tag_t          cdb_tag,
    output packet_pkg::rob_alloc_packet rob_alloc,
    output logic                        retire_valid,
    output arch_pkg::reg_idx_t          retire_rd,
    output arch_pkg::rob_tag_t          retire_tag
);
    import arch_pkg::*;

    // slot pointer and occupancy
    typedef logic [rob_idx_len-1:0] slot_t;
    typedef logic [rob_idx_len:0]   count_t;

    ////////////////////
    // storage
    ////////////////////

    // destination register per entry
    reg_idx_t [rob_depth-1:0] entry_rd;
    // result seen on the bus
    logic [rob_depth-1:0]     entry_done;

    // oldest entry
    slot_t  head_q;
    // next free slot
    slot_t  tail_q;
    // live entries from 0 to rob_depth
    count_t count_q;

    logic   full;
    logic   alloc;
    logic   pop;

    // broadcast slot and its distance from head
    slot_t  cdb_slot;
    slot_t  cdb_offset;
    logic   cdb_live;

    ////////////////////
    // control
    ////////////////////

    assign full  = (count_q == count_t'(rob_depth));
    // squash drops the dispatch of that cycle
    assign alloc = dispatch_enable && !squash;
    // head leaves once done and at most one per cycle
    assign pop   = !squash && (count_q != '0) && entry_done[head_q];

    // broadcast must fall inside head..head+count
    assign cdb_slot   = cdb_tag[rob_idx_len-1:0];
    assign cdb_offset = cdb_slot - head_q;
    assign cdb_live   = !cdb_tag[rob_idx_len] && (count_t'(cdb_offset) < count_q);

    ////////////////////
    // outputs
    ////////////////////

    // tag handed to this cycle's dispatch
    assign rob_alloc.tail = {1'b0, tail_q};
    assign rob_alloc.full = full;

    assign retire_valid = pop;
    assign retire_rd    = entry_rd[head_q];
    assign retire_tag   = {1'b0, head_q};

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (squash) begin
            // restart allocation at tag 0
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // pointers wrap with the slot width
            if (alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + count_t'(alloc) - count_t'(pop);
        end
    end

    // done flags
    // later writes win on a shared slot
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entry_done <= '0;
        end else if (squash) begin
            entry_done <= '0;
        end else begin
            if (pop) begin
                entry_done[head_q] <= 1'b0;
            end
            if (cdb_valid && cdb_live) begin
                entry_done[cdb_slot] <= 1'b1;
            end
            if (alloc) begin
                entry_done[tail_q] <= 1'b0;
            end
        end
    end

    // destination written at allocation
    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_rd[tail_q] <= dispatch_rd;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // dispatch holds off on full
    no_dispatch_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        dispatch_enable |-> !full
    ) else $error("reorder_buffer: dispatch while full");

    // broadcast names an allocated slot
    cdb_hits_entry: assert property (
        @(posedge clock) disable iff (!rst_n)
        cdb_valid |-> cdb_live
    ) else $error("reorder_buffer: broadcast to empty slot %0d", cdb_slot);

endmodule
